// File: include/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_CSR_A_W 14
`define SOC_CSR_REG_W 10

// CSR bank numbers, upper address bits
`define SOC_BANK_SYSCTL 1
`define SOC_BANK_IRQ 2

// GPIO and interrupt widths
`define SOC_GPIO_IN_N 7
`define SOC_GPIO_OUT_N 2
`define SOC_IRQ_N 8

// Reset timing in sys_clk cycles, flash release comes first
`define SOC_RST_HOLD_CYCLES 64
`define SOC_FLASH_RST_CYCLES 16

`define SOC_SYSTEM_ID 32'h4D4F4E45

`endif

// File: source/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

	// ----------------------------------------
	// CSR bus
	// ----------------------------------------
	typedef logic [`SOC_DATA_W-1:0] csr_data_t;
	typedef logic [`SOC_CSR_A_W-1:0] csr_addr_t;

	typedef struct packed {
		csr_addr_t adr;
		logic      we;
		csr_data_t dat;
	} csr_req_t;

	// ----------------------------------------
	// Wishbone classic slave port
	// ----------------------------------------
	// Word address, no byte selects
	typedef struct packed {
		logic [31:0] adr;
		csr_data_t   dat;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	typedef struct packed {
		csr_data_t dat;
		logic      ack;
	} wb_rsp_t;

	// ----------------------------------------
	// Board signals
	// ----------------------------------------
	// PCB revision in the upper four bits, buttons below
	typedef logic [`SOC_GPIO_IN_N-1:0] gpio_in_t;
	typedef logic [`SOC_GPIO_OUT_N-1:0] gpio_out_t;
	typedef logic [`SOC_IRQ_N-1:0] irq_vec_t;

endpackage

// File: source/reset_sequencer.sv
`include "soc_cfg.svh"

module reset_sequencer (
	input  logic       sys_clk,
	input  logic       trigger_reset,
	input  logic [2:0] buttons_i,
	input  logic       hard_reset_i,
	output logic       sys_rst_o,
	output logic       periph_rst_n_o,
	output logic       flash_rst_n_o
);

	localparam int HOLD_W = $clog2(`SOC_RST_HOLD_CYCLES);
	localparam int FLASH_W = $clog2(`SOC_FLASH_RST_CYCLES);

	logic               trigger_q;
	logic [HOLD_W-1:0]  hold_cnt;
	logic [FLASH_W-1:0] flash_cnt;
	logic               sys_rst_q;

	// All three buttons held together count as a reset request
	always_ff @(posedge sys_clk) begin
		trigger_q <= trigger_reset | (&buttons_i) | hard_reset_i;
	end

	// ----------------------------------------
	// Debounce hold for the system reset
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_q) begin
			hold_cnt <= HOLD_W'(`SOC_RST_HOLD_CYCLES - 1);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		sys_rst_q <= trigger_q | (hold_cnt != '0);
	end

	// Boot flash leaves reset well before the system does,
	// so it is ready to read when the first fetch comes
	always_ff @(posedge sys_clk) begin
		if (trigger_q) begin
			flash_cnt <= FLASH_W'(`SOC_FLASH_RST_CYCLES - 1);
		end else if (flash_cnt != '0) begin
			flash_cnt <= flash_cnt - 1'b1;
		end
	end

	assign sys_rst_o = sys_rst_q;
	assign periph_rst_n_o = ~sys_rst_q;
	assign flash_rst_n_o = (flash_cnt == '0);

endmodule

// File: source/csr_bridge.sv
`include "soc_cfg.svh"

module csr_bridge (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  soc_pkg::wb_req_t   wb_req_i,
	output soc_pkg::wb_rsp_t   wb_rsp_o,
	output soc_pkg::csr_req_t  csr_req_o,
	input  soc_pkg::csr_data_t csr_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_RETURN
	} state_t;

	state_t             state;
	logic               req_valid;
	logic               ack_q;
	logic               csr_we_q;
	soc_pkg::csr_addr_t csr_adr_q;
	soc_pkg::csr_data_t csr_dat_q;
	soc_pkg::csr_data_t rsp_dat_q;

	// The ack cycle itself never starts a new access,
	// so the master always gets one idle cycle to drop stb
	assign req_valid = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// ----------------------------------------
	// Sequencing
	// ----------------------------------------
	// Idle: latch address, banks start the read
	// Access: read data registered in the banks, write strobe goes out
	// Return: write lands, ORed read data captured, ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			csr_we_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			csr_we_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						state <= ST_ACCESS;
					end
				end
				ST_ACCESS: begin
					csr_we_q <= wb_req_i.we;
					state <= ST_RETURN;
				end
				ST_RETURN: begin
					ack_q <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------
	// Address, write data and read data
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && req_valid) begin
			// Word address, low bits reach the CSR bus
			csr_adr_q <= wb_req_i.adr[`SOC_CSR_A_W-1:0];
			csr_dat_q <= wb_req_i.dat;
		end
		if (state == ST_RETURN) begin
			rsp_dat_q <= csr_rdata_i;
		end
	end

	assign csr_req_o = '{adr: csr_adr_q, we: csr_we_q, dat: csr_dat_q};
	assign wb_rsp_o = '{dat: rsp_dat_q, ack: ack_q};

endmodule

// File: source/sysctl_bank.sv
`include "soc_cfg.svh"

module sysctl_bank #(
	parameter int BANK_ID = `SOC_BANK_SYSCTL
) (
	input  logic                sys_clk,
	input  logic                sys_rst_i,
	input  soc_pkg::csr_req_t   csr_req_i,
	output soc_pkg::csr_data_t  csr_rdata_o,
	input  soc_pkg::gpio_in_t   gpio_i,
	output soc_pkg::gpio_out_t  gpio_o,
	output logic                gpio_irq_o,
	output logic                hard_reset_o
);

	localparam int SEL_W = `SOC_CSR_A_W - `SOC_CSR_REG_W;

	localparam logic [`SOC_CSR_REG_W-1:0] REG_ID = 'd0;
	localparam logic [`SOC_CSR_REG_W-1:0] REG_GPIO_IN = 'd1;
	localparam logic [`SOC_CSR_REG_W-1:0] REG_GPIO_OUT = 'd2;
	localparam logic [`SOC_CSR_REG_W-1:0] REG_RESET = 'd3;

	logic                        bank_sel;
	logic [`SOC_CSR_REG_W-1:0]   reg_idx;
	soc_pkg::gpio_in_t           gpio_meta;
	soc_pkg::gpio_in_t           gpio_sync;
	soc_pkg::gpio_in_t           gpio_last;

	assign bank_sel = (csr_req_i.adr[`SOC_CSR_A_W-1:`SOC_CSR_REG_W] == SEL_W'(BANK_ID));
	assign reg_idx = csr_req_i.adr[`SOC_CSR_REG_W-1:0];

	// ----------------------------------------
	// GPIO input synchronizer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
		gpio_last <= gpio_sync;
	end

	// One cycle pulse on any edge of any input
	assign gpio_irq_o = |(gpio_sync ^ gpio_last);

	// ----------------------------------------
	// Register writes
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_o <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= 1'b0;
			if (bank_sel && csr_req_i.we) begin
				case (reg_idx)
					REG_GPIO_OUT: gpio_o <= csr_req_i.dat[`SOC_GPIO_OUT_N-1:0];
					// Written value is ignored
					REG_RESET: hard_reset_o <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// Read data one cycle after the address, zero when not selected
	always_ff @(posedge sys_clk) begin
		csr_rdata_o <= '0;
		if (bank_sel) begin
			case (reg_idx)
				REG_ID: csr_rdata_o <= `SOC_SYSTEM_ID;
				REG_GPIO_IN: csr_rdata_o <= soc_pkg::csr_data_t'(gpio_sync);
				REG_GPIO_OUT: csr_rdata_o <= soc_pkg::csr_data_t'(gpio_o);
				default: csr_rdata_o <= '0;
			endcase
		end
	end

endmodule

// File: source/irq_bank.sv
`include "soc_cfg.svh"

module irq_bank #(
	parameter int BANK_ID = `SOC_BANK_IRQ
) (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  soc_pkg::csr_req_t  csr_req_i,
	output soc_pkg::csr_data_t csr_rdata_o,
	input  soc_pkg::irq_vec_t  irq_sources_i,
	output logic               irq_o
);

	localparam int SEL_W = `SOC_CSR_A_W - `SOC_CSR_REG_W;

	localparam logic [`SOC_CSR_REG_W-1:0] REG_PENDING = 'd0;
	localparam logic [`SOC_CSR_REG_W-1:0] REG_MASK = 'd1;

	logic                      bank_sel;
	logic [`SOC_CSR_REG_W-1:0] reg_idx;
	logic                      wr_pending;
	logic                      wr_mask;
	soc_pkg::irq_vec_t         clear_bits;
	soc_pkg::irq_vec_t         pending;
	soc_pkg::irq_vec_t         mask;

	assign bank_sel = (csr_req_i.adr[`SOC_CSR_A_W-1:`SOC_CSR_REG_W] == SEL_W'(BANK_ID));
	assign reg_idx = csr_req_i.adr[`SOC_CSR_REG_W-1:0];
	assign wr_pending = bank_sel & csr_req_i.we & (reg_idx == REG_PENDING);
	assign wr_mask = bank_sel & csr_req_i.we & (reg_idx == REG_MASK);

	// Write one to clear
	assign clear_bits = wr_pending ? csr_req_i.dat[`SOC_IRQ_N-1:0] : '0;

	// ----------------------------------------
	// Pending and mask
	// ----------------------------------------
	// A source that is still high wins over the clear
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			pending <= '0;
			mask <= '0;
		end else begin
			pending <= (pending & ~clear_bits) | irq_sources_i;
			if (wr_mask) begin
				mask <= csr_req_i.dat[`SOC_IRQ_N-1:0];
			end
		end
	end

	assign irq_o = |(pending & mask);

	// ----------------------------------------
	// Read data
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		csr_rdata_o <= '0;
		if (bank_sel) begin
			case (reg_idx)
				REG_PENDING: csr_rdata_o <= soc_pkg::csr_data_t'(pending);
				REG_MASK: csr_rdata_o <= soc_pkg::csr_data_t'(mask);
				default: csr_rdata_o <= '0;
			endcase
		end
	end

endmodule

// File: source/soc_top.sv
`include "soc_cfg.svh"

module soc_top (
	input  logic               sys_clk,
	input  logic               trigger_reset,
	input  soc_pkg::wb_req_t   wb_req_i,
	output soc_pkg::wb_rsp_t   wb_rsp_o,
	input  soc_pkg::gpio_in_t  gpio_i,
	output soc_pkg::gpio_out_t gpio_o,
	input  soc_pkg::irq_vec_t  ext_irq_i,
	output logic               irq_o,
	output logic               flash_rst_n_o,
	output logic               periph_rst_n_o
);

	logic               sys_rst;
	logic               hard_reset;
	logic               gpio_irq;
	soc_pkg::irq_vec_t  irq_vec;
	soc_pkg::csr_req_t  csr_req;
	soc_pkg::csr_data_t csr_dr_sysctl;
	soc_pkg::csr_data_t csr_dr_irq;

	// ----------------------------------------
	// Reset generation
	// ----------------------------------------
	// Buttons sit in the low three GPIO input bits
	reset_sequencer reset_sequencer_inst (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.buttons_i      (gpio_i[2:0]),
		.hard_reset_i   (hard_reset),
		.sys_rst_o      (sys_rst),
		.periph_rst_n_o (periph_rst_n_o),
		.flash_rst_n_o  (flash_rst_n_o)
	);

	// ----------------------------------------
	// Wishbone to CSR
	// ----------------------------------------
	// Banks drive zero when not addressed
	csr_bridge csr_bridge_inst (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.wb_req_i    (wb_req_i),
		.wb_rsp_o    (wb_rsp_o),
		.csr_req_o   (csr_req),
		.csr_rdata_i (csr_dr_sysctl | csr_dr_irq)
	);

	sysctl_bank #(
		.BANK_ID (`SOC_BANK_SYSCTL)
	) sysctl_bank_inst (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_req_i    (csr_req),
		.csr_rdata_o  (csr_dr_sysctl),
		.gpio_i       (gpio_i),
		.gpio_o       (gpio_o),
		.gpio_irq_o   (gpio_irq),
		.hard_reset_o (hard_reset)
	);

	// GPIO takes bit 0, the external line there is dropped
	assign irq_vec = {ext_irq_i[`SOC_IRQ_N-1:1], gpio_irq};

	irq_bank #(
		.BANK_ID (`SOC_BANK_IRQ)
	) irq_bank_inst (
		.sys_clk       (sys_clk),
		.sys_rst_i     (sys_rst),
		.csr_req_i     (csr_req),
		.csr_rdata_o   (csr_dr_irq),
		.irq_sources_i (irq_vec),
		.irq_o         (irq_o)
	);

endmodule

// File: sim/soc_top_tb.sv
`include "soc_cfg.svh"

module soc_top_tb;

	localparam int MAX_PATTERNS = 64;
	localparam logic [31:0] SEED = 32'h904d_2590;

	// Operation codes in the first column of the pattern file
	localparam int OP_END = 0;
	localparam int OP_WRITE = 1;
	localparam int OP_READ = 2;
	localparam int OP_SET_INPUT = 3;
	localparam int OP_CHECK_IRQ = 4;
	localparam int OP_WAIT_RESET = 5;
	localparam int OP_CHECK_GPIO = 6;

	logic               sys_clk = 1'b0;
	logic               trigger_reset;
	soc_pkg::wb_req_t   wb_req;
	soc_pkg::wb_rsp_t   wb_rsp;
	soc_pkg::gpio_in_t  gpio_in;
	soc_pkg::gpio_out_t gpio_out;
	soc_pkg::irq_vec_t  ext_irq;
	logic               irq;
	logic               flash_rst_n;
	logic               periph_rst_n;

	// Each pattern holds op, address, data and expected value
	logic [31:0] patterns [0:4*MAX_PATTERNS-1];
	int          pattern_count;

	soc_top soc_top_inst (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_req_i       (wb_req),
		.wb_rsp_o       (wb_rsp),
		.gpio_i         (gpio_in),
		.gpio_o         (gpio_out),
		.ext_irq_i      (ext_irq),
		.irq_o          (irq),
		.flash_rst_n_o  (flash_rst_n),
		.periph_rst_n_o (periph_rst_n)
	);

	always #10 sys_clk = ~sys_clk;

	// ----------------------------------------
	// Error reporting and compare tasks
	// ----------------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_data(input string name, input soc_pkg::csr_data_t expected,
			input soc_pkg::csr_data_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERR %0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_irq(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERR %0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_gpio(input string name, input soc_pkg::gpio_out_t expected,
			input soc_pkg::gpio_out_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERR %0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_reset(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERR %0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------
	// Leaves the caller at the drive point after the next rising edge
	task automatic next_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	// One Wishbone classic cycle with ack on the third edge
	task automatic bus_access(input logic we, input logic [31:0] adr,
			input soc_pkg::csr_data_t wdat, output soc_pkg::csr_data_t rdat);
		int   edges;
		logic ack_seen;
		edges = 0;
		ack_seen = 1'b0;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		wb_req.we = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		while (!ack_seen && edges < 8) begin
			@(posedge sys_clk);
			edges++;
			@(negedge sys_clk);
			ack_seen = wb_rsp.ack;
		end
		if (!ack_seen) begin
			abort_run($sformatf("No Wishbone ack within 8 cycles for address %h", adr));
		end
		if (edges != 3) begin
			abort_run($sformatf("Wishbone ack came after %0d edges instead of 3", edges));
		end
		rdat = wb_rsp.dat;
		next_cycle();
		if (wb_rsp.ack !== 1'b0) begin
			abort_run("Wishbone ack stayed high for more than one cycle");
		end
		wb_req = '0;
	endtask

	task automatic set_input(input logic [31:0] sel, input logic [31:0] value);
		if (sel == 0) begin
			gpio_in = value[`SOC_GPIO_IN_N-1:0];
		end else begin
			ext_irq = value[`SOC_IRQ_N-1:0];
		end
		// Two synchronizer stages and the pending register
		repeat (4) next_cycle();
	endtask

	// Flash must be out of reset strictly before the peripherals
	task automatic wait_reset_release();
		int   cycles;
		logic flash_up;
		cycles = 0;
		flash_up = 1'b0;
		while (periph_rst_n !== 1'b1) begin
			@(negedge sys_clk);
			if (periph_rst_n === 1'b1 && !flash_up) begin
				abort_run("periph_rst_n_o was released before flash_rst_n_o");
			end
			if (flash_rst_n === 1'b1) begin
				flash_up = 1'b1;
			end
			cycles++;
			if (cycles > 2 * `SOC_RST_HOLD_CYCLES) begin
				abort_run("periph_rst_n_o was not released in time");
			end
		end
		next_cycle();
	endtask

	task automatic hard_reset_cycle();
		int cycles;
		cycles = 0;
		@(negedge sys_clk);
		while (periph_rst_n !== 1'b0) begin
			cycles++;
			if (cycles > 8) begin
				abort_run("Hard reset request did not pull periph_rst_n_o low");
			end
			@(negedge sys_clk);
		end
		check_reset("flash_rst_n_o", 1'b0, flash_rst_n);
		wait_reset_release();
	endtask

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------
	initial begin
		#1;
		repeat (pattern_count * 40 + 2 * `SOC_RST_HOLD_CYCLES) @(posedge sys_clk);
		abort_run("Watchdog expired before all patterns were done");
	end

	initial begin
		logic [31:0]        op;
		logic [31:0]        adr;
		logic [31:0]        dat;
		logic [31:0]        expected;
		soc_pkg::csr_data_t rdat;

		trigger_reset = 1'b1;
		wb_req = '0;
		gpio_in = '0;
		ext_irq = '0;
		void'($urandom(SEED));

		for (int i = 0; i < 4 * MAX_PATTERNS; i++) begin
			patterns[i] = '0;
		end
		$readmemh("sim/soc_patterns.txt", patterns);
		pattern_count = 0;
		while (pattern_count < MAX_PATTERNS && patterns[4 * pattern_count] != OP_END) begin
			pattern_count++;
		end
		if (pattern_count == 0) begin
			abort_run("No patterns were read from sim/soc_patterns.txt");
		end

		// Power-on reset with trigger high for eight edges
		repeat (7) @(posedge sys_clk);
		@(negedge sys_clk);
		check_reset("flash_rst_n_o", 1'b0, flash_rst_n);
		check_reset("periph_rst_n_o", 1'b0, periph_rst_n);
		next_cycle();
		trigger_reset = 1'b0;
		wait_reset_release();

		for (int i = 0; i < pattern_count; i++) begin
			op = patterns[4 * i];
			adr = patterns[4 * i + 1];
			dat = patterns[4 * i + 2];
			expected = patterns[4 * i + 3];
			case (op)
				OP_WRITE: bus_access(1'b1, adr, dat, rdat);
				OP_READ: begin
					bus_access(1'b0, adr, '0, rdat);
					check_data($sformatf("wb_rsp_o.dat from %h", adr), expected, rdat);
				end
				OP_SET_INPUT: set_input(adr, dat);
				OP_CHECK_IRQ: begin
					@(negedge sys_clk);
					check_irq("irq_o", expected[0], irq);
					next_cycle();
				end
				OP_WAIT_RESET: hard_reset_cycle();
				OP_CHECK_GPIO: begin
					@(negedge sys_clk);
					check_gpio("gpio_o", soc_pkg::gpio_out_t'(expected), gpio_out);
					next_cycle();
				end
				default: abort_run($sformatf("Pattern %0d has unknown operation %h", i, op));
			endcase
			// Random gap between operations
			repeat ($urandom % 3) next_cycle();
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
source/soc_pkg.sv
source/reset_sequencer.sv
source/csr_bridge.sv
source/sysctl_bank.sv
source/irq_bank.sv
source/soc_top.sv
sim/soc_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module soc_top_tb \
	-f verilog.f \
	-Mdir obj_dir -o soc_top_tb_sim

./obj_dir/soc_top_tb_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished, log in sim.log"

// File: sim/soc_patterns.txt
// Columns: op address data expected, all hex
// op 1 write, 2 read and compare, 3 set input (address 0 gpio_i, 1 ext_irq_i),
// op 4 check irq_o, 5 wait through hard reset, 6 check gpio_o, 0 end
2 00000400 00000000 4D4F4E45
2 00000404 00000000 00000000
2 00000C00 00000000 00000000
1 00000402 00000003 00000000
6 00000000 00000000 00000003
2 00000402 00000000 00000003
3 00000000 00000058 00000000
2 00000401 00000000 00000058
2 00000800 00000000 00000001
4 00000000 00000000 00000000
1 00000801 00000001 00000000
4 00000000 00000000 00000001
1 00000800 00000001 00000000
4 00000000 00000000 00000000
2 00000800 00000000 00000000
3 00000001 00000020 00000000
2 00000800 00000000 00000020
4 00000000 00000000 00000000
1 00000801 00000021 00000000
4 00000000 00000000 00000001
1 00000800 00000020 00000000
2 00000800 00000000 00000020
3 00000001 00000000 00000000
1 00000800 00000020 00000000
4 00000000 00000000 00000000
2 00000800 00000000 00000000
1 00000403 00000000 00000000
5 00000000 00000000 00000000
6 00000000 00000000 00000000
2 00000801 00000000 00000000
2 00000400 00000000 4D4F4E45
0 00000000 00000000 00000000
